/* bench/lcdControllerTb.sv */
`timescale 1ns/1ns

module lcdControllerTb import lcdPkg::*; ();

  typedef busWord_t wordQ_t[$];

  logic    clk;
  logic    rst;
  lcdReq_t req;
  logic    reqValid;
  logic    busy;
  logic    done;
  lcdBus_t lcdPins;

  integer  seed = 36;
  lcdReq_t reqList[$];
  string   nameList[$];
  wordQ_t  expWords;
  lcdOp_e  expOp;
  string   curName;
  int      errors;
  int      passCount;
  int      failCount;
  int      issued;
  int      doneCount;
  int      cycleCount;
  int      cycleLimit;

  lcdController UUT (
    .clk(clk), .rst(rst), .req(req), .reqValid(reqValid),
    .busy(busy), .done(done), .lcdPins(lcdPins)
  );

  tbBusMonitor busMon (.clk(clk), .rst(rst), .lcdPins(lcdPins));

  always #4 clk = !clk;

  function automatic logic [15:0] rgb565(colorSel_e c);
    case (c)
      colRed:   return 16'hF800;
      colGreen: return 16'h07E0;
      colBlue:  return 16'h001F;
      colBlack: return 16'h0000;
      default:  return 16'hFFFF;
    endcase
  endfunction

  function automatic busWord_t cmdWord(logic [7:0] v);
    return '{isData: 1'b0, value: v};
  endfunction

  function automatic busWord_t dataWord(logic [7:0] v);
    return '{isData: 1'b1, value: v};
  endfunction

  // expected panel writes for one request
  function automatic wordQ_t expectedWords(lcdReq_t r);
    wordQ_t q;
    logic [15:0] color;
    int pixelCount;
    case (r.op)
      opInit: begin
        q.push_back(cmdWord(8'h10));
        q.push_back(cmdWord(8'h01));
        q.push_back(cmdWord(8'h11));
        q.push_back(cmdWord(8'h3A));
        q.push_back(dataWord(8'h55));
        q.push_back(cmdWord(8'h36));
        q.push_back(dataWord(8'hB8));
        q.push_back(cmdWord(8'h29));
      end
      opDispOff: begin
        q.push_back(cmdWord(8'h28));
        q.push_back(cmdWord(8'h10));
      end
      opDispOn: begin
        q.push_back(cmdWord(8'h11));
        q.push_back(cmdWord(8'h29));
      end
      opFill: begin
        q.push_back(cmdWord(8'h2A));
        q.push_back(dataWord(r.xStart[15:8]));
        q.push_back(dataWord(r.xStart[7:0]));
        q.push_back(dataWord(r.xEnd[15:8]));
        q.push_back(dataWord(r.xEnd[7:0]));
        q.push_back(cmdWord(8'h2B));
        q.push_back(dataWord(r.yStart[15:8]));
        q.push_back(dataWord(r.yStart[7:0]));
        q.push_back(dataWord(r.yEnd[15:8]));
        q.push_back(dataWord(r.yEnd[7:0]));
        q.push_back(cmdWord(8'h2C));
        color = rgb565(r.color);
        pixelCount = (int'(r.xEnd) - int'(r.xStart) + 1) * (int'(r.yEnd) - int'(r.yStart) + 1);
        for (int i = 0; i < pixelCount; i++) begin
          q.push_back(dataWord(color[15:8]));
          q.push_back(dataWord(color[7:0]));
        end
      end
      default: ;
    endcase
    return q;
  endfunction

  // minimum latch-to-latch gap after word idx of a script
  function automatic int minGap(lcdOp_e op, int idx);
    if (op == opInit && idx < 2) return 40;
    if (op == opInit && idx == 2) return 20;
    if ((op == opDispOff || op == opDispOn) && idx == 0) return 10;
    return 0;
  endfunction

  function automatic int waitTotal(lcdOp_e op);
    case (op)
      opInit:    return 100;
      opDispOff: return 50;
      opDispOn:  return 20;
      default:   return 0;
    endcase
  endfunction

  task automatic checkValue(string signal, logic [15:0] expected, logic [15:0] got);
    if (expected !== got) begin
      $display("[FAIL] %0t ns: %s expected %0h got %0h", $time, signal, expected, got);
      errors++;
    end
  endtask

  task automatic reportTest(string name);
    if (errors == 0) begin
      passCount++;
      $display("test %0d %s: pass", passCount + failCount, name);
    end else begin
      failCount++;
      $display("test %0d %s: %0d errors", passCount + failCount, name, errors);
    end
  endtask

  task automatic runRequest(lcdReq_t r, string name);
    @(posedge clk);
    errors = 0;
    // csx must be back high between requests
    checkValue({name, " csx before request"}, 1, lcdPins.csx);
    expWords = expectedWords(r);
    expOp = r.op;
    curName = name;
    issued <= issued + 1;
    req <= r;
    reqValid <= 1'b1;
    // busy is high in the cycle after acceptance
    repeat (2) @(posedge clk);
    checkValue({name, " busy"}, 1, busy);
    while (!done) begin
      @(posedge clk);
    end
    reqValid <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("run stopped at cycle %0d, no done seen for %s", cycleCount, curName);
      $display("Test FAILED");
      $finish;
    end
  end

  // compares the captured bus words once each done arrives
  always @(posedge clk) begin
    if (done) begin
      doneCount++;
      if (doneCount != issued) begin
        $display("%s: %0d done pulses seen for %0d requests", curName, doneCount, issued);
        errors++;
      end
      checkValue({curName, " csx at done"}, 1, lcdPins.csx);
      if (busMon.words.size() != expWords.size()) begin
        $display("%s: %0d words latched, %0d expected", curName, busMon.words.size(),
                 expWords.size());
        errors++;
      end else begin
        for (int i = 0; i < expWords.size(); i++) begin
          checkValue($sformatf("%s dcx of word %0d", curName, i), expWords[i].isData,
                     busMon.words[i].isData);
          checkValue($sformatf("%s data of word %0d", curName, i), expWords[i].value,
                     busMon.words[i].value);
          if (i + 1 < expWords.size() &&
              busMon.latchCycle[i + 1] - busMon.latchCycle[i] < minGap(expOp, i)) begin
            $display("%s: wait after word %0d lasted only %0d cycles", curName, i,
                     busMon.latchCycle[i + 1] - busMon.latchCycle[i]);
            errors++;
          end
        end
      end
      if (busMon.csxRises != ((expOp == opNone) ? 0 : 1)) begin
        $display("%s: csx rose %0d times", curName, busMon.csxRises);
        errors++;
      end
      reportTest(curName);
      busMon.clearCapture();
    end
  end

  initial begin
    lcdReq_t r;
    int a;
    int b;
    int totalWait;
    int totalWords;
    wordQ_t listed;
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    reqValid = 1'b0;
    passCount = 0;
    failCount = 0;
    issued = 0;
    doneCount = 0;
    cycleCount = 0;
    cycleLimit = 1000000;
    r = '0;
    r.op = opInit;
    reqList.push_back(r);
    nameList.push_back("init");
    r.op = opDispOff;
    reqList.push_back(r);
    nameList.push_back("display off");
    r.op = opDispOn;
    reqList.push_back(r);
    nameList.push_back("display on");
    for (int k = 0; k < 5; k++) begin
      r = '{op: opFill, color: colorSel_e'(k), xStart: 16'(k), xEnd: 16'(k + 1),
            yStart: 16'd2, yEnd: 16'd3};
      reqList.push_back(r);
      nameList.push_back($sformatf("fill 2x2 color %0d", k));
    end
    for (int k = 0; k < 6; k++) begin
      r.op = opFill;
      r.color = colorSel_e'((($random(seed) & 32'h7fff_ffff) % 5));
      a = $random(seed) & 7;
      b = $random(seed) & 7;
      r.xStart = 16'((a < b) ? a : b);
      r.xEnd = 16'((a < b) ? b : a);
      a = $random(seed) & 7;
      b = $random(seed) & 7;
      r.yStart = 16'((a < b) ? a : b);
      r.yEnd = 16'((a < b) ? b : a);
      reqList.push_back(r);
      nameList.push_back($sformatf("random fill %0d", k));
    end
    // back-to-back group including requests with no bus activity
    r.op = opNone;
    reqList.push_back(r);
    nameList.push_back("back-to-back none");
    r.op = opDispOn;
    reqList.push_back(r);
    nameList.push_back("back-to-back display on");
    r = '{op: opFill, color: colWhite, xStart: 16'd5, xEnd: 16'd5, yStart: 16'd1, yEnd: 16'd1};
    reqList.push_back(r);
    nameList.push_back("back-to-back fill");
    r.op = opNone;
    reqList.push_back(r);
    nameList.push_back("back-to-back none again");
    totalWait = 0;
    totalWords = 0;
    foreach (reqList[i]) begin
      totalWait += waitTotal(reqList[i].op);
      listed = expectedWords(reqList[i]);
      totalWords += listed.size();
    end
    cycleLimit = 2 * totalWait + 4 * totalWords + 200;

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    errors = 0;
    checkValue("csx", 1, lcdPins.csx);
    checkValue("dcx", 1, lcdPins.dcx);
    checkValue("wrx", 1, lcdPins.wrx);
    checkValue("data", 0, lcdPins.data);
    checkValue("busy", 0, busy);
    checkValue("done", 0, done);
    reportTest("reset values");

    foreach (reqList[i]) begin
      runRequest(reqList[i], nameList[i]);
    end
    repeat (4) @(posedge clk);
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* bench/tbBusMonitor.sv */
`timescale 1ns/1ns

module tbBusMonitor import lcdPkg::*; (
  input logic    clk,
  input logic    rst,
  input lcdBus_t lcdPins
);

  // words latched by the panel, with the cycle of each latch
  busWord_t words[$];
  int       latchCycle[$];
  int       csxRises;
  int       cycle;
  logic     prevWrx;
  logic     prevCsx;

  initial begin
    csxRises = 0;
    cycle = 0;
    prevWrx = 1'b1;
    prevCsx = 1'b1;
  end

  task automatic clearCapture();
    words.delete();
    latchCycle.delete();
    csxRises = 0;
  endtask

  // pins are registered, so sampling on the clock sees settled values
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      prevWrx = 1'b1;
      prevCsx = 1'b1;
    end else begin
      if (!prevWrx && lcdPins.wrx && !lcdPins.csx) begin
        words.push_back('{isData: lcdPins.dcx, value: lcdPins.data});
        latchCycle.push_back(cycle);
      end
      if (!prevCsx && lcdPins.csx) begin
        csxRises = csxRises + 1;
      end
      prevWrx = lcdPins.wrx;
      prevCsx = lcdPins.csx;
    end
  end

endmodule

/* filelist.f */
src/lcdPkg.sv
src/scriptRom.sv
src/pixelFill.sv
src/busWriter.sv
src/lcdSequencer.sv
src/lcdController.sv
bench/tbBusMonitor.sv
bench/lcdControllerTb.sv

/* src/busWriter.sv */
`timescale 1ns/1ns

module busWriter import lcdPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     select,
  input  logic     wordValid,
  input  busWord_t word,
  output logic     wordReady,
  output lcdBus_t  lcdPins
);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      lcdPins <= '{csx: 1'b1, dcx: 1'b1, wrx: 1'b1, data: 8'h00};
      wordReady <= 1'b1;
    end else begin
      lcdPins.csx <= !select;
      if (wordValid && wordReady) begin
        // first half of the strobe, dcx and data set up with wrx low
        lcdPins.wrx <= 1'b0;
        lcdPins.dcx <= word.isData;
        lcdPins.data <= word.value;
        wordReady <= 1'b0;
      end else if (!wordReady) begin
        // panel latches on this rising edge
        lcdPins.wrx <= 1'b1;
        wordReady <= 1'b1;
      end
    end
  end

  strobeInsideSelect: assert property (
    @(posedge clk) disable iff (rst)
    !lcdPins.wrx |-> !lcdPins.csx
  );

endmodule

/* src/lcdController.sv */
`timescale 1ns/1ns

module lcdController import lcdPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  lcdReq_t req,
  input  logic    reqValid,
  output logic    busy,
  output logic    done,
  output lcdBus_t lcdPins
);

  lcdOp_e                          scriptOp;
  logic [$clog2(SCRIPT_DEPTH)-1:0] stepIndex;
  scriptStep_t                     step;
  logic                            fillStart;
  lcdReq_t                         fillReq;
  logic                            fillValid;
  logic                            fillLast;
  busWord_t                        fillWord;
  logic                            fillTake;
  logic                            wordValid;
  busWord_t                        word;
  logic                            wordReady;
  logic                            select;

  lcdSequencer sequencer (
    .clk(clk), .rst(rst), .req(req), .reqValid(reqValid), .busy(busy), .done(done),
    .scriptOp(scriptOp), .stepIndex(stepIndex), .step(step),
    .fillStart(fillStart), .fillReq(fillReq), .fillValid(fillValid), .fillLast(fillLast),
    .fillWord(fillWord), .fillTake(fillTake),
    .wordValid(wordValid), .word(word), .wordReady(wordReady), .select(select)
  );

  scriptRom rom (.scriptOp(scriptOp), .stepIndex(stepIndex), .step(step));

  pixelFill filler (
    .clk(clk), .rst(rst), .start(fillStart), .fillReq(fillReq), .fillValid(fillValid),
    .fillLast(fillLast), .fillWord(fillWord), .fillTake(fillTake)
  );

  busWriter writer (
    .clk(clk), .rst(rst), .select(select), .wordValid(wordValid), .word(word),
    .wordReady(wordReady), .lcdPins(lcdPins)
  );

endmodule

/* src/lcdPkg.sv */
package lcdPkg;

  typedef enum logic [2:0] {
    opNone,
    opInit,
    opDispOn,
    opDispOff,
    opFill
  } lcdOp_e;

  typedef enum logic [2:0] {
    colRed,
    colGreen,
    colBlue,
    colBlack,
    colWhite
  } colorSel_e;

  typedef struct packed {
    lcdOp_e      op;
    colorSel_e   color;
    logic [15:0] xStart;
    logic [15:0] xEnd;
    logic [15:0] yStart;
    logic [15:0] yEnd;
  } lcdReq_t;

  // isData high selects parameter or pixel, low selects command
  typedef struct packed {
    logic       isData;
    logic [7:0] value;
  } busWord_t;

  typedef struct packed {
    logic       csx;
    logic       dcx;
    logic       wrx;
    logic [7:0] data;
  } lcdBus_t;

  typedef enum logic [1:0] {
    stepCmd,
    stepParam,
    stepWait,
    stepEnd
  } scriptStep_e;

  typedef struct packed {
    scriptStep_e kind;
    logic [7:0]  arg;
  } scriptStep_t;

  localparam logic [7:0] CMD_SLEEP_IN   = 8'h10;
  localparam logic [7:0] CMD_SW_RESET   = 8'h01;
  localparam logic [7:0] CMD_SLEEP_OUT  = 8'h11;
  localparam logic [7:0] CMD_PIX_FMT    = 8'h3A;
  localparam logic [7:0] CMD_MADCTL     = 8'h36;
  localparam logic [7:0] CMD_DISP_ON    = 8'h29;
  localparam logic [7:0] CMD_DISP_OFF   = 8'h28;
  localparam logic [7:0] CMD_COL_ADDR   = 8'h2A;
  localparam logic [7:0] CMD_PAGE_ADDR  = 8'h2B;
  localparam logic [7:0] CMD_MEM_WRITE  = 8'h2C;

  localparam logic [7:0] PIX_FMT_16BIT  = 8'h55;
  localparam logic [7:0] MADCTL_VALUE   = 8'hB8;

  // simulation-sized, scale up for a real panel
  localparam logic [15:0] WAIT_SLEEP = 16'd40;
  localparam logic [15:0] WAIT_RESET = 16'd40;
  localparam logic [15:0] WAIT_WAKE  = 16'd20;
  localparam logic [15:0] WAIT_SHORT = 16'd10;

  // argument of a wait step
  localparam logic [7:0] WAIT_ID_SLEEP = 8'd0;
  localparam logic [7:0] WAIT_ID_RESET = 8'd1;
  localparam logic [7:0] WAIT_ID_WAKE  = 8'd2;
  localparam logic [7:0] WAIT_ID_SHORT = 8'd3;

  localparam int SCRIPT_DEPTH = 16;

  function automatic logic [15:0] waitLength(logic [7:0] waitId);
    case (waitId)
      WAIT_ID_SLEEP: return WAIT_SLEEP;
      WAIT_ID_RESET: return WAIT_RESET;
      WAIT_ID_WAKE:  return WAIT_WAKE;
      default:       return WAIT_SHORT;
    endcase
  endfunction

  // RGB565
  function automatic logic [15:0] colorWord(colorSel_e color);
    case (color)
      colRed:   return 16'hF800;
      colGreen: return 16'h07E0;
      colBlue:  return 16'h001F;
      colBlack: return 16'h0000;
      default:  return 16'hFFFF;
    endcase
  endfunction

endpackage

/* src/lcdSequencer.sv */
`timescale 1ns/1ns

module lcdSequencer import lcdPkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  lcdReq_t                         req,
  input  logic                            reqValid,
  output logic                            busy,
  output logic                            done,
  output lcdOp_e                          scriptOp,
  output logic [$clog2(SCRIPT_DEPTH)-1:0] stepIndex,
  input  scriptStep_t                     step,
  output logic                            fillStart,
  output lcdReq_t                         fillReq,
  input  logic                            fillValid,
  input  logic                            fillLast,
  input  busWord_t                        fillWord,
  output logic                            fillTake,
  output logic                            wordValid,
  output busWord_t                        word,
  input  logic                            wordReady,
  output logic                            select
);

  typedef enum logic [2:0] {
    sIdle,
    sOpen,
    sScript,
    sWait,
    sFill,
    sClose,
    sFinish
  } seqState_e;

  seqState_e   state;
  seqState_e   nextState;
  lcdReq_t     reqQ;
  logic [15:0] waitCnt;
  logic        finishDly;
  logic        waitStep;

  assign scriptOp = reqQ.op;
  assign fillReq = reqQ;
  assign busy = (state != sIdle);
  assign fillStart = (state == sOpen) && (reqQ.op == opFill);
  assign waitStep = (state == sScript) && (step.kind == stepWait);
  // keep csx low until the last strobe has finished
  assign select = (state inside {sOpen, sScript, sWait, sFill}) ||
                  ((state == sClose) && !wordReady);

  always_comb begin
    wordValid = 1'b0;
    word = '{isData: 1'b0, value: 8'h00};
    fillTake = 1'b0;
    case (state)
      sScript: begin
        if (step.kind == stepCmd || step.kind == stepParam) begin
          wordValid = 1'b1;
          word = '{isData: (step.kind == stepParam), value: step.arg};
        end
      end
      sFill: begin
        wordValid = fillValid;
        word = fillWord;
        fillTake = fillValid && wordReady;
      end
      default: ;
    endcase
  end

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (reqValid) begin
          nextState = (req.op == opNone) ? sFinish : sOpen;
        end
      end
      sOpen: nextState = (reqQ.op == opFill) ? sFill : sScript;
      sScript: begin
        // a wait only begins once the previous write is complete
        if (waitStep && wordReady) begin
          nextState = sWait;
        end else if (step.kind == stepEnd) begin
          nextState = sClose;
        end
      end
      sWait: if (waitCnt == 16'd0) nextState = sScript;
      sFill: if (fillTake && fillLast) nextState = sClose;
      sClose: if (wordReady) nextState = sFinish;
      sFinish: if (!reqValid && finishDly && !done) nextState = sIdle;
      default: nextState = sIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == sIdle && reqValid) begin
      reqQ <= req;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= sIdle;
      stepIndex <= '0;
      waitCnt <= 16'd0;
      finishDly <= 1'b0;
      done <= 1'b0;
    end else begin
      state <= nextState;
      finishDly <= (state == sFinish);
      // csx is already high by the second finish cycle
      done <= (state == sFinish) && !finishDly;
      if (state == sIdle) begin
        stepIndex <= '0;
      end else if ((wordValid && wordReady && state == sScript) || (waitStep && wordReady)) begin
        stepIndex <= stepIndex + 1'b1;
      end
      if (waitStep) begin
        waitCnt <= waitLength(step.arg);
      end else if (state == sWait && waitCnt != 16'd0) begin
        waitCnt <= waitCnt - 16'd1;
      end
    end
  end

  doneOnlyInFinish: assert property (
    @(posedge clk) disable iff (rst)
    done |-> (state == sFinish)
  );

  fillWindowOrdered: assert property (
    @(posedge clk) disable iff (rst)
    (state == sIdle && reqValid && req.op == opFill) |->
      (req.xStart <= req.xEnd) && (req.yStart <= req.yEnd)
  );

endmodule

/* src/pixelFill.sv */
`timescale 1ns/1ns

module pixelFill import lcdPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  lcdReq_t  fillReq,
  output logic     fillValid,
  output logic     fillLast,
  output busWord_t fillWord,
  input  logic     fillTake
);

  typedef enum logic [1:0] {
    colAddr,
    pageAddr,
    memCmd,
    pixels
  } fillPhase_e;

  fillPhase_e  phase;
  lcdReq_t     reqQ;
  logic        active;
  logic [2:0]  wordIdx;
  logic        lowByte;
  logic [31:0] pixelCnt;
  logic [16:0] spanX;
  logic [16:0] spanY;
  logic [33:0] area;
  logic [15:0] color;

  // command, then start and end coordinates, high byte first
  function automatic busWord_t addrWord(logic [7:0] cmd, logic [15:0] first,
                                        logic [15:0] last, logic [2:0] idx);
    case (idx)
      3'd0:    return '{isData: 1'b0, value: cmd};
      3'd1:    return '{isData: 1'b1, value: first[15:8]};
      3'd2:    return '{isData: 1'b1, value: first[7:0]};
      3'd3:    return '{isData: 1'b1, value: last[15:8]};
      default: return '{isData: 1'b1, value: last[7:0]};
    endcase
  endfunction

  assign spanX = {1'b0, fillReq.xEnd} - {1'b0, fillReq.xStart} + 17'd1;
  assign spanY = {1'b0, fillReq.yEnd} - {1'b0, fillReq.yStart} + 17'd1;
  assign area = spanX * spanY;
  assign color = colorWord(reqQ.color);

  assign fillValid = active;
  assign fillLast = active && (phase == pixels) && lowByte && (pixelCnt == 32'd1);

  always_comb begin
    case (phase)
      colAddr:  fillWord = addrWord(CMD_COL_ADDR, reqQ.xStart, reqQ.xEnd, wordIdx);
      pageAddr: fillWord = addrWord(CMD_PAGE_ADDR, reqQ.yStart, reqQ.yEnd, wordIdx);
      memCmd:   fillWord = '{isData: 1'b0, value: CMD_MEM_WRITE};
      default:  fillWord = '{isData: 1'b1, value: lowByte ? color[7:0] : color[15:8]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (start) begin
      reqQ <= fillReq;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      active <= 1'b0;
      phase <= colAddr;
      wordIdx <= 3'd0;
      lowByte <= 1'b0;
      pixelCnt <= 32'd0;
    end else if (start) begin
      active <= 1'b1;
      phase <= colAddr;
      wordIdx <= 3'd0;
      lowByte <= 1'b0;
      pixelCnt <= area[31:0];
    end else if (active && fillTake) begin
      case (phase)
        colAddr, pageAddr: begin
          if (wordIdx == 3'd4) begin
            wordIdx <= 3'd0;
            phase <= (phase == colAddr) ? pageAddr : memCmd;
          end else begin
            wordIdx <= wordIdx + 3'd1;
          end
        end
        memCmd: phase <= pixels;
        default: begin
          lowByte <= !lowByte;
          // a pixel is done once its low byte goes out
          if (lowByte) begin
            pixelCnt <= pixelCnt - 32'd1;
            if (fillLast) begin
              active <= 1'b0;
            end
          end
        end
      endcase
    end
  end

endmodule

/* src/scriptRom.sv */
`timescale 1ns/1ns

module scriptRom import lcdPkg::*; (
  input  lcdOp_e                          scriptOp,
  input  logic [$clog2(SCRIPT_DEPTH)-1:0] stepIndex,
  output scriptStep_t                     step
);

  always_comb begin
    step = '{kind: stepEnd, arg: 8'h00};
    case (scriptOp)
      opInit: begin
        case (stepIndex)
          4'd0:  step = '{kind: stepCmd,   arg: CMD_SLEEP_IN};
          4'd1:  step = '{kind: stepWait,  arg: WAIT_ID_SLEEP};
          4'd2:  step = '{kind: stepCmd,   arg: CMD_SW_RESET};
          4'd3:  step = '{kind: stepWait,  arg: WAIT_ID_RESET};
          4'd4:  step = '{kind: stepCmd,   arg: CMD_SLEEP_OUT};
          4'd5:  step = '{kind: stepWait,  arg: WAIT_ID_WAKE};
          4'd6:  step = '{kind: stepCmd,   arg: CMD_PIX_FMT};
          4'd7:  step = '{kind: stepParam, arg: PIX_FMT_16BIT};
          4'd8:  step = '{kind: stepCmd,   arg: CMD_MADCTL};
          4'd9:  step = '{kind: stepParam, arg: MADCTL_VALUE};
          4'd10: step = '{kind: stepCmd,   arg: CMD_DISP_ON};
          default: ;
        endcase
      end
      opDispOff: begin
        // blank first, then let the panel settle into sleep
        case (stepIndex)
          4'd0: step = '{kind: stepCmd,  arg: CMD_DISP_OFF};
          4'd1: step = '{kind: stepWait, arg: WAIT_ID_SHORT};
          4'd2: step = '{kind: stepCmd,  arg: CMD_SLEEP_IN};
          4'd3: step = '{kind: stepWait, arg: WAIT_ID_SLEEP};
          default: ;
        endcase
      end
      opDispOn: begin
        case (stepIndex)
          4'd0: step = '{kind: stepCmd,  arg: CMD_SLEEP_OUT};
          4'd1: step = '{kind: stepWait, arg: WAIT_ID_SHORT};
          4'd2: step = '{kind: stepCmd,  arg: CMD_DISP_ON};
          4'd3: step = '{kind: stepWait, arg: WAIT_ID_SHORT};
          default: ;
        endcase
      end
      // fill and none have no script
      default: ;
    endcase
  end

endmodule
